//--- source/shader_params.svh
`ifndef SHADER_PARAMS_SVH
`define SHADER_PARAMS_SVH

// Core geometry
`define SHADER_LANES 4
`define GROUP_BITS 2

// Register numbers and operand fields
`define SGPR_BITS 4
`define VGPR_BITS 4
`define IMM_BITS 12

// Data widths
`define WORD_BITS 32
`define PC_BITS 30

// Register files, tables and the constant ROM all share this read latency
`define REGFILE_STAGES 3

// Issue to result, including the output register in the top level
`define OPERAND_LATENCY 7

`endif

//--- source/shader_pkg.sv
`include "shader_params.svh"

package shader_pkg;

	typedef logic [`WORD_BITS-1:0] word;

	typedef logic [`SGPR_BITS-1:0] sgpr_num;

	typedef logic [`VGPR_BITS-1:0] vgpr_num;

	typedef logic [`GROUP_BITS-1:0] group_id;

	typedef logic [`SHADER_LANES-1:0] lane_mask;

	typedef logic [`PC_BITS-1:0] word_ptr;

	typedef logic [`IMM_BITS-1:0] imm_t;

	// One data word per lane
	typedef word lane_words [`SHADER_LANES];

	// Where scalar operand B comes from
	typedef enum logic [1:0] {
		SRC_SGPR  = 2'd0,
		SRC_IMM   = 2'd1,
		SRC_CONST = 2'd2
	} operand_src;

endpackage

//--- source/shader_regfile.sv
`timescale 1ns/1ps

`include "shader_params.svh"

module shader_regfile
	import shader_pkg::*;
#(
	parameter int DEPTH_LOG = 1
) (
	input  logic                 clk,

	input  logic [DEPTH_LOG-1:0] read_a_num,
	input  logic [DEPTH_LOG-1:0] read_b_num,
	output word                  read_a_data,
	output word                  read_b_data,

	input  logic                 write,
	input  logic [DEPTH_LOG-1:0] write_num,
	input  word                  write_data
);

	localparam int PIPE = `REGFILE_STAGES - 1;

	// Both copies always hold the same contents, one per read port
	word file_a [1 << DEPTH_LOG];
	word file_b [1 << DEPTH_LOG];

	logic                 write_q;
	logic [DEPTH_LOG-1:0] write_num_q;
	word                  write_data_q;

	logic [DEPTH_LOG-1:0] read_a_num_q;
	logic [DEPTH_LOG-1:0] read_b_num_q;
	word                  a_pipe [PIPE];
	word                  b_pipe [PIPE];

	always_ff @(posedge clk) begin
		write_q <= write;
		write_num_q <= write_num;
		write_data_q <= write_data;

		if (write_q) begin
			file_a[write_num_q] <= write_data_q;
			file_b[write_num_q] <= write_data_q;
		end
	end

	always_ff @(posedge clk) begin
		read_a_num_q <= read_a_num;
		read_b_num_q <= read_b_num;

		a_pipe[0] <= file_a[read_a_num_q];
		b_pipe[0] <= file_b[read_b_num_q];
		for (int i = 1; i < PIPE; i++) begin
			a_pipe[i] <= a_pipe[i - 1];
			b_pipe[i] <= b_pipe[i - 1];
		end
	end

	assign read_a_data = a_pipe[PIPE - 1];
	assign read_b_data = b_pipe[PIPE - 1];

endmodule

//--- source/shader_const_rom.sv
`timescale 1ns/1ps

`include "shader_params.svh"

module shader_const_rom
	import shader_pkg::*;
(
	input  logic    clk,

	input  sgpr_num num,
	output word     value
);

	localparam int PIPE = `REGFILE_STAGES - 1;

	sgpr_num num_q;
	word     rom_data;
	word     value_pipe [PIPE];

	always_comb begin
		case (num_q)
			4'd0:    rom_data = 32'hffff_ffff;
			4'd1:    rom_data = 32'h7fff_ffff;
			4'd2:    rom_data = 32'h8000_0000;
			// IEEE single precision +1.0 and -1.0
			4'd3:    rom_data = 32'h3f80_0000;
			4'd4:    rom_data = 32'hbf80_0000;
			default: rom_data = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		num_q <= num;
		value_pipe[0] <= rom_data;
		for (int i = 1; i < PIPE; i++)
			value_pipe[i] <= value_pipe[i - 1];
	end

	assign value = value_pipe[PIPE - 1];

endmodule

//--- source/shader_group_table.sv
`timescale 1ns/1ps

`include "shader_params.svh"

module shader_group_table
	import shader_pkg::*;
#(
	parameter int DATA_WIDTH = 1,
	parameter int READ_PORTS = 1
) (
	input  logic                  clk,

	input  group_id               write_group,
	input  logic                  write_enable,
	input  logic [DATA_WIDTH-1:0] write,

	input  group_id               read_groups [READ_PORTS],
	output logic [DATA_WIDTH-1:0] read [READ_PORTS]
);

	localparam int GROUPS = 1 << `GROUP_BITS;
	localparam int PIPE = `REGFILE_STAGES - 1;

	logic                  write_enable_q;
	group_id               write_group_q;
	logic [DATA_WIDTH-1:0] write_q;

	always_ff @(posedge clk) begin
		write_enable_q <= write_enable;
		write_group_q <= write_group;
		write_q <= write;
	end

	// A private copy of the table per read port
	generate
		for (genvar p = 0; p < READ_PORTS; p++) begin : g_port
			logic [DATA_WIDTH-1:0] data [GROUPS];
			group_id               read_group_q;
			logic [DATA_WIDTH-1:0] read_pipe [PIPE];

			always_ff @(posedge clk) begin
				if (write_enable_q)
					data[write_group_q] <= write_q;

				read_group_q <= read_groups[p];
				read_pipe[0] <= data[read_group_q];
				for (int i = 1; i < PIPE; i++)
					read_pipe[i] <= read_pipe[i - 1];
			end

			assign read[p] = read_pipe[PIPE - 1];
		end
	endgenerate

endmodule

//--- source/shader_operand_ctrl.sv
`timescale 1ns/1ps

`include "shader_params.svh"

module shader_operand_ctrl
	import shader_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	input  logic       op_valid,
	input  group_id    op_group,
	input  sgpr_num    a_sgpr,
	input  vgpr_num    a_vgpr,
	input  vgpr_num    b_vgpr,
	input  imm_t       b_imm,
	input  logic       a_scalar,
	input  logic       b_scalar,
	input  logic       b_is_imm,
	input  logic       b_is_const,
	input  logic       scalar_rev,

	output group_id    sgpr_a_group,
	output sgpr_num    sgpr_a_num,
	output group_id    vgpr_group,
	output vgpr_num    vgpr_a_num,
	output vgpr_num    vgpr_b_num,
	output operand_src b_src,
	output word        imm_word,
	output logic       swap,
	output logic       a_bcast,
	output logic       b_bcast,
	output logic       valid_out
);

	localparam int SRC_DELAY = `REGFILE_STAGES;
	localparam int SWAP_DELAY = `REGFILE_STAGES + 1;
	localparam int BCAST_DELAY = `REGFILE_STAGES + 2;
	// The top level registers the last stage
	localparam int VALID_DELAY = `OPERAND_LATENCY - 1;

	operand_src              b_src_issue;
	operand_src              src_pipe [SRC_DELAY];
	word                     imm_pipe [SRC_DELAY];
	logic [SWAP_DELAY-1:0]   swap_pipe;
	logic [BCAST_DELAY-1:0]  a_bcast_pipe;
	logic [BCAST_DELAY-1:0]  b_bcast_pipe;
	logic [VALID_DELAY-1:0]  valid_pipe;

	group_id group_q1;
	group_id group_q2;
	sgpr_num a_sgpr_q;
	vgpr_num a_vgpr_q1;
	vgpr_num a_vgpr_q2;
	vgpr_num b_vgpr_q1;
	vgpr_num b_vgpr_q2;

	// Immediate wins over the constant ROM
	always_comb begin
		if (b_is_imm)
			b_src_issue = SRC_IMM;
		else if (b_is_const)
			b_src_issue = SRC_CONST;
		else
			b_src_issue = SRC_SGPR;
	end

	always_ff @(posedge clk) begin
		a_sgpr_q <= a_sgpr;
		group_q1 <= op_group;
		group_q2 <= group_q1;

		a_vgpr_q1 <= a_vgpr;
		a_vgpr_q2 <= a_vgpr_q1;
		b_vgpr_q1 <= b_vgpr;
		b_vgpr_q2 <= b_vgpr_q1;

		src_pipe[0] <= b_src_issue;
		imm_pipe[0] <= {{(`WORD_BITS - `IMM_BITS){1'b0}}, b_imm};
		for (int i = 1; i < SRC_DELAY; i++) begin
			src_pipe[i] <= src_pipe[i - 1];
			imm_pipe[i] <= imm_pipe[i - 1];
		end

		swap_pipe <= {swap_pipe[SWAP_DELAY-2:0], scalar_rev};
		a_bcast_pipe <= {a_bcast_pipe[BCAST_DELAY-2:0], a_scalar};
		b_bcast_pipe <= {b_bcast_pipe[BCAST_DELAY-2:0], b_scalar};
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			valid_pipe <= '0;
		else
			valid_pipe <= {valid_pipe[VALID_DELAY-2:0], op_valid};
	end

	assign sgpr_a_group = group_q1;
	assign sgpr_a_num = a_sgpr_q;
	assign vgpr_group = group_q2;
	assign vgpr_a_num = a_vgpr_q2;
	assign vgpr_b_num = b_vgpr_q2;
	assign b_src = src_pipe[SRC_DELAY - 1];
	assign imm_word = imm_pipe[SRC_DELAY - 1];
	assign swap = swap_pipe[SWAP_DELAY - 1];
	assign a_bcast = a_bcast_pipe[BCAST_DELAY - 1];
	assign b_bcast = b_bcast_pipe[BCAST_DELAY - 1];
	assign valid_out = valid_pipe[VALID_DELAY - 1];

	// The issuer picks at most one non-register source for B
	a_one_b_source: assert property (@(posedge clk) disable iff (!rst_n)
		op_valid |-> !(b_is_imm && b_is_const));

	a_reset_flush: assert property (@(posedge clk) !rst_n |=> !valid_out);

endmodule

//--- source/shader_operand_mux.sv
`timescale 1ns/1ps

`include "shader_params.svh"

module shader_operand_mux
	import shader_pkg::*;
(
	input  logic       clk,

	input  operand_src b_src,
	input  word        imm_word,
	input  word        const_value,
	input  word        sgpr_a_data,
	input  word        sgpr_b_data,

	input  logic       swap,
	input  logic       a_bcast,
	input  logic       b_bcast,

	input  lane_words  vgpr_a_data,
	input  lane_words  vgpr_b_data,

	output lane_words  lane_a,
	output lane_words  lane_b
);

	word scalar_b_q;
	word scalar_a_out;
	word scalar_b_out;

	// SGPR A arrives one cycle after SGPR B, so B is held here until then
	always_ff @(posedge clk) begin
		case (b_src)
			SRC_IMM:   scalar_b_q <= imm_word;
			SRC_CONST: scalar_b_q <= const_value;
			default:   scalar_b_q <= sgpr_b_data;
		endcase
	end

	always_ff @(posedge clk) begin
		if (swap) begin
			scalar_a_out <= scalar_b_q;
			scalar_b_out <= sgpr_a_data;
		end else begin
			scalar_a_out <= sgpr_a_data;
			scalar_b_out <= scalar_b_q;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `SHADER_LANES; i++) begin
			lane_a[i] <= a_bcast ? scalar_a_out : vgpr_a_data[i];
			lane_b[i] <= b_bcast ? scalar_b_out : vgpr_b_data[i];
		end
	end

	// The source code is built in the control module and must survive its delay line
	a_legal_src: assert property (@(posedge clk)
		!$isunknown(b_src) |-> b_src inside {SRC_SGPR, SRC_IMM, SRC_CONST});

endmodule

//--- source/shader_regs_top.sv
`timescale 1ns/1ps

`include "shader_params.svh"

module shader_regs_top
	import shader_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	input  logic      op_valid,
	input  group_id   op_group,
	input  sgpr_num   a_sgpr,
	input  sgpr_num   b_sgpr,
	input  vgpr_num   a_vgpr,
	input  vgpr_num   b_vgpr,
	input  imm_t      b_imm,
	input  logic      a_scalar,
	input  logic      b_scalar,
	input  logic      b_is_imm,
	input  logic      b_is_const,
	input  logic      scalar_rev,

	input  logic      sgpr_write,
	input  group_id   sgpr_wr_group,
	input  sgpr_num   sgpr_wr_num,
	input  word       sgpr_wr_data,

	input  lane_mask  vgpr_wr_mask,
	input  group_id   vgpr_wr_group,
	input  vgpr_num   vgpr_wr_num,
	input  lane_words vgpr_wr_data,

	input  logic      pc_wb_write,
	input  group_id   pc_wb_group,
	input  word_ptr   pc_wb,

	input  logic      mask_wb_write,
	input  group_id   mask_wb_group,
	input  lane_mask  mask_wb,

	input  group_id   pc_front_group,
	input  group_id   pc_back_group,
	input  group_id   mask_back_group,
	output word_ptr   pc_front,
	output word_ptr   pc_back,
	output lane_mask  mask_back,

	output logic      out_valid,
	output lane_words a,
	output lane_words b
);

	localparam int PC_PORTS = 2;
	localparam int MASK_PORTS = 1;

	group_id    sgpr_a_group;
	sgpr_num    sgpr_a_num;
	group_id    vgpr_group;
	vgpr_num    vgpr_a_num;
	vgpr_num    vgpr_b_num;
	operand_src b_src;
	word        imm_word;
	logic       swap;
	logic       a_bcast;
	logic       b_bcast;
	logic       ctrl_valid;

	word        sgpr_a_data;
	word        sgpr_b_data;
	word        const_value;
	lane_words  vgpr_a_data;
	lane_words  vgpr_b_data;
	lane_words  lane_a;
	lane_words  lane_b;

	group_id    pc_read_groups [PC_PORTS];
	word_ptr    pc_read [PC_PORTS];
	group_id    mask_read_groups [MASK_PORTS];
	lane_mask   mask_read [MASK_PORTS];

	assign pc_read_groups[0] = pc_back_group;
	assign pc_read_groups[1] = pc_front_group;
	assign pc_back = pc_read[0];
	assign pc_front = pc_read[1];

	assign mask_read_groups[0] = mask_back_group;
	assign mask_back = mask_read[0];

	shader_operand_ctrl ctrl (
		.clk,
		.rst_n,
		.op_valid,
		.op_group,
		.a_sgpr,
		.a_vgpr,
		.b_vgpr,
		.b_imm,
		.a_scalar,
		.b_scalar,
		.b_is_imm,
		.b_is_const,
		.scalar_rev,
		.sgpr_a_group,
		.sgpr_a_num,
		.vgpr_group,
		.vgpr_a_num,
		.vgpr_b_num,
		.b_src,
		.imm_word,
		.swap,
		.a_bcast,
		.b_bcast,
		.valid_out(ctrl_valid)
	);

	// B is read straight at issue, A one cycle later so it lines up with the swap
	shader_regfile #(.DEPTH_LOG(`GROUP_BITS + `SGPR_BITS)) sgprs (
		.clk,
		.read_a_num({sgpr_a_group, sgpr_a_num}),
		.read_b_num({op_group, b_sgpr}),
		.read_a_data(sgpr_a_data),
		.read_b_data(sgpr_b_data),
		.write(sgpr_write),
		.write_num({sgpr_wr_group, sgpr_wr_num}),
		.write_data(sgpr_wr_data)
	);

	generate
		for (genvar i = 0; i < `SHADER_LANES; i++) begin : g_vgpr
			shader_regfile #(.DEPTH_LOG(`GROUP_BITS + `VGPR_BITS)) vgprs (
				.clk,
				.read_a_num({vgpr_group, vgpr_a_num}),
				.read_b_num({vgpr_group, vgpr_b_num}),
				.read_a_data(vgpr_a_data[i]),
				.read_b_data(vgpr_b_data[i]),
				.write(vgpr_wr_mask[i]),
				.write_num({vgpr_wr_group, vgpr_wr_num}),
				.write_data(vgpr_wr_data[i])
			);
		end
	endgenerate

	shader_const_rom consts (
		.clk,
		.num(b_sgpr),
		.value(const_value)
	);

	shader_group_table #(.DATA_WIDTH(`PC_BITS), .READ_PORTS(PC_PORTS)) pc_table (
		.clk,
		.write_group(pc_wb_group),
		.write_enable(pc_wb_write),
		.write(pc_wb),
		.read_groups(pc_read_groups),
		.read(pc_read)
	);

	shader_group_table #(.DATA_WIDTH(`SHADER_LANES), .READ_PORTS(MASK_PORTS)) mask_table (
		.clk,
		.write_group(mask_wb_group),
		.write_enable(mask_wb_write),
		.write(mask_wb),
		.read_groups(mask_read_groups),
		.read(mask_read)
	);

	shader_operand_mux mux (
		.clk,
		.b_src,
		.imm_word,
		.const_value,
		.sgpr_a_data,
		.sgpr_b_data,
		.swap,
		.a_bcast,
		.b_bcast,
		.vgpr_a_data,
		.vgpr_b_data,
		.lane_a,
		.lane_b
	);

	always_ff @(posedge clk) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= ctrl_valid;
	end

	always_ff @(posedge clk) begin
		a <= lane_a;
		b <= lane_b;
	end

endmodule

//--- testbench/shader_regs_tb.sv
`timescale 1ns/1ps

`include "shader_params.svh"

module shader_regs_tb
	import shader_pkg::*;
();

	localparam int LANES = `SHADER_LANES;
	localparam int GROUPS = 1 << `GROUP_BITS;
	localparam int SGPRS = 1 << `SGPR_BITS;
	localparam int VGPRS = 1 << `VGPR_BITS;
	localparam int ROUNDS = 40;
	localparam int DRAIN_LIMIT = 100;

	logic      clk;
	logic      rst_n;
	logic      op_valid;
	group_id   op_group;
	sgpr_num   a_sgpr;
	sgpr_num   b_sgpr;
	vgpr_num   a_vgpr;
	vgpr_num   b_vgpr;
	imm_t      b_imm;
	logic      a_scalar;
	logic      b_scalar;
	logic      b_is_imm;
	logic      b_is_const;
	logic      scalar_rev;
	logic      sgpr_write;
	group_id   sgpr_wr_group;
	sgpr_num   sgpr_wr_num;
	word       sgpr_wr_data;
	lane_mask  vgpr_wr_mask;
	group_id   vgpr_wr_group;
	vgpr_num   vgpr_wr_num;
	lane_words vgpr_wr_data;
	logic      pc_wb_write;
	group_id   pc_wb_group;
	word_ptr   pc_wb;
	logic      mask_wb_write;
	group_id   mask_wb_group;
	lane_mask  mask_wb;
	group_id   pc_front_group;
	group_id   pc_back_group;
	group_id   mask_back_group;
	word_ptr   pc_front;
	word_ptr   pc_back;
	lane_mask  mask_back;
	logic      out_valid;
	lane_words a;
	lane_words b;

	// High while the table read groups driven this cycle are to be checked
	logic tbl_probe;
	logic monitor_on;

	int seed;
	int ncount;
	int value_errors;
	int timing_errors;
	int drain_timeouts;

	// Reference model of every storage element in the DUT
	word      sgpr_m [GROUPS][SGPRS];
	word      vgpr_m [LANES][GROUPS][VGPRS];
	word_ptr  pc_m [GROUPS];
	lane_mask mask_m [GROUPS];
	word      const_m [SGPRS];

	word      exp_a_q [$];
	word      exp_b_q [$];
	int       due_q [$];
	word_ptr  pc_front_q [$];
	word_ptr  pc_back_q [$];
	lane_mask mask_back_q [$];
	int       tbl_due_q [$];

	shader_regs_top shader_regs_top_i (.*);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	function automatic word rand_word();
		return $random(seed);
	endfunction

	task automatic check_word(input string name, input int lane, input word got,
		input word exp);
		if (got !== exp) begin
			$display("error: %s[%0d] got %h expected %h", name, lane, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_ptr(input string name, input word_ptr got, input word_ptr exp);
		if (got !== exp) begin
			$display("error: %s got %h expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_mask(input string name, input lane_mask got, input lane_mask exp);
		if (got !== exp) begin
			$display("error: %s got %h expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic load_const_model();
		for (int i = 0; i < SGPRS; i++)
			const_m[i] = '0;
		const_m[0] = 32'hffff_ffff;
		const_m[1] = 32'h7fff_ffff;
		const_m[2] = 32'h8000_0000;
		const_m[3] = 32'h3f80_0000;
		const_m[4] = 32'hbf80_0000;
	endtask

	// Waits for the next rising edge and drops every strobe; callers then raise what they need
	task automatic next_cycle();
		@(posedge clk);
		op_valid <= 1'b0;
		tbl_probe <= 1'b0;
		sgpr_write <= 1'b0;
		vgpr_wr_mask <= '0;
		pc_wb_write <= 1'b0;
		mask_wb_write <= 1'b0;
	endtask

	task automatic write_sgpr(input group_id g, input sgpr_num n);
		word d;
		d = rand_word();
		sgpr_write <= 1'b1;
		sgpr_wr_group <= g;
		sgpr_wr_num <= n;
		sgpr_wr_data <= d;
		sgpr_m[g][n] = d;
	endtask

	task automatic write_vgpr(input lane_mask m, input group_id g, input vgpr_num n);
		word d;
		vgpr_wr_mask <= m;
		vgpr_wr_group <= g;
		vgpr_wr_num <= n;
		for (int l = 0; l < LANES; l++) begin
			d = rand_word();
			vgpr_wr_data[l] <= d;
			if (m[l])
				vgpr_m[l][g][n] = d;
		end
	endtask

	task automatic write_pc(input group_id g);
		word f;
		f = rand_word();
		pc_wb_write <= 1'b1;
		pc_wb_group <= g;
		pc_wb <= f[`PC_BITS-1:0];
		pc_m[g] = f[`PC_BITS-1:0];
	endtask

	task automatic write_mask(input group_id g);
		word f;
		f = rand_word();
		mask_wb_write <= 1'b1;
		mask_wb_group <= g;
		mask_wb <= f[LANES-1:0];
		mask_m[g] = f[LANES-1:0];
	endtask

	// SGPR and VGPR files have the same depth, so one pass fills both
	task automatic fill_all();
		for (int g = 0; g < GROUPS; g++) begin
			for (int n = 0; n < SGPRS; n++) begin
				next_cycle();
				write_sgpr(group_id'(g), sgpr_num'(n));
				write_vgpr('1, group_id'(g), vgpr_num'(n));
				if (n == 0) begin
					write_pc(group_id'(g));
					write_mask(group_id'(g));
				end
			end
		end
	endtask

	task automatic random_write_cycle();
		word sel;
		word f;
		next_cycle();
		sel = rand_word();
		f = rand_word();
		if (sel[0])
			write_sgpr(f[0 +: `GROUP_BITS], f[4 +: `SGPR_BITS]);
		if (sel[1])
			write_vgpr(sel[8 +: LANES], f[12 +: `GROUP_BITS], f[16 +: `VGPR_BITS]);
		if (sel[2])
			write_pc(f[20 +: `GROUP_BITS]);
		if (sel[3])
			write_mask(f[24 +: `GROUP_BITS]);
	endtask

	task automatic issue_random_op();
		word     f;
		word     r;
		int      src;
		group_id g;
		sgpr_num as_n;
		sgpr_num bs_n;
		vgpr_num av_n;
		vgpr_num bv_n;
		imm_t    imm;
		word     sa;
		word     sb;
		word     t;
		group_id pf;
		group_id pb;
		group_id mb;
		group_id nz;

		next_cycle();
		f = rand_word();
		r = rand_word();
		src = int'(rand_word() % 3);
		g = f[0 +: `GROUP_BITS];
		as_n = f[4 +: `SGPR_BITS];
		bs_n = f[8 +: `SGPR_BITS];
		av_n = f[12 +: `VGPR_BITS];
		bv_n = f[16 +: `VGPR_BITS];
		imm = f[20 +: `IMM_BITS];
		pf = r[4 +: `GROUP_BITS];
		mb = r[8 +: `GROUP_BITS];
		nz = r[12 +: `GROUP_BITS];
		if (nz == '0)
			nz = 1;
		pb = pf ^ nz;

		sa = sgpr_m[g][as_n];
		if (src == 1)
			sb = word'(imm);
		else if (src == 2)
			sb = const_m[bs_n];
		else
			sb = sgpr_m[g][bs_n];
		if (r[2]) begin
			t = sa;
			sa = sb;
			sb = t;
		end
		for (int l = 0; l < LANES; l++) begin
			exp_a_q.push_back(r[0] ? sa : vgpr_m[l][g][av_n]);
			exp_b_q.push_back(r[1] ? sb : vgpr_m[l][g][bv_n]);
		end
		pc_front_q.push_back(pc_m[pf]);
		pc_back_q.push_back(pc_m[pb]);
		mask_back_q.push_back(mask_m[mb]);

		op_valid <= 1'b1;
		op_group <= g;
		a_sgpr <= as_n;
		b_sgpr <= bs_n;
		a_vgpr <= av_n;
		b_vgpr <= bv_n;
		b_imm <= imm;
		a_scalar <= r[0];
		b_scalar <= r[1];
		scalar_rev <= r[2];
		b_is_imm <= (src == 1);
		b_is_const <= (src == 2);
		tbl_probe <= 1'b1;
		pc_front_group <= pf;
		pc_back_group <= pb;
		mask_back_group <= mb;
	endtask

	task automatic check_operands();
		logic due_now;
		word  ea;
		word  eb;
		due_now = 1'b0;
		if (due_q.size() != 0)
			due_now = (due_q[0] == ncount);
		if (out_valid !== 1'b0 && !due_now) begin
			$display("Unexpected out_valid at cycle %0d with no operation due", ncount);
			timing_errors++;
		end else if (due_now) begin
			void'(due_q.pop_front());
			if (out_valid !== 1'b1) begin
				$display("Missing out_valid at cycle %0d for an issued operation", ncount);
				timing_errors++;
			end
			for (int l = 0; l < LANES; l++) begin
				ea = exp_a_q.pop_front();
				eb = exp_b_q.pop_front();
				if (out_valid === 1'b1) begin
					check_word("a", l, a[l], ea);
					check_word("b", l, b[l], eb);
				end
			end
		end
	endtask

	task automatic check_tables();
		if (tbl_due_q.size() != 0) begin
			if (tbl_due_q[0] == ncount) begin
				void'(tbl_due_q.pop_front());
				check_ptr("pc_front", pc_front, pc_front_q.pop_front());
				check_ptr("pc_back", pc_back, pc_back_q.pop_front());
				check_mask("mask_back", mask_back, mask_back_q.pop_front());
			end
		end
	endtask

	// Outputs settle after the rising edge, so they are sampled on the falling one
	always @(negedge clk) begin
		if (monitor_on) begin
			ncount++;
			if (op_valid)
				due_q.push_back(ncount + `OPERAND_LATENCY);
			if (tbl_probe)
				tbl_due_q.push_back(ncount + `REGFILE_STAGES);
			check_operands();
			check_tables();
		end
	end

	task automatic drain_results();
		int waited;
		waited = 0;
		while ((due_q.size() != 0 || tbl_due_q.size() != 0) && waited < DRAIN_LIMIT) begin
			next_cycle();
			waited++;
		end
		if (due_q.size() != 0 || tbl_due_q.size() != 0) begin
			$display("Timed out waiting for %0d outstanding results", due_q.size());
			drain_timeouts++;
		end
	endtask

	initial begin
		int n;
		seed = 32'h5bfc_6409;
		ncount = 0;
		value_errors = 0;
		timing_errors = 0;
		drain_timeouts = 0;
		rst_n <= 1'b0;
		monitor_on <= 1'b0;
		tbl_probe <= 1'b0;
		op_valid <= 1'b0;
		op_group <= '0;
		a_sgpr <= '0;
		b_sgpr <= '0;
		a_vgpr <= '0;
		b_vgpr <= '0;
		b_imm <= '0;
		a_scalar <= 1'b0;
		b_scalar <= 1'b0;
		b_is_imm <= 1'b0;
		b_is_const <= 1'b0;
		scalar_rev <= 1'b0;
		sgpr_write <= 1'b0;
		sgpr_wr_group <= '0;
		sgpr_wr_num <= '0;
		sgpr_wr_data <= '0;
		vgpr_wr_mask <= '0;
		vgpr_wr_group <= '0;
		vgpr_wr_num <= '0;
		for (int l = 0; l < LANES; l++)
			vgpr_wr_data[l] <= '0;
		pc_wb_write <= 1'b0;
		pc_wb_group <= '0;
		pc_wb <= '0;
		mask_wb_write <= 1'b0;
		mask_wb_group <= '0;
		mask_wb <= '0;
		pc_front_group <= '0;
		pc_back_group <= '0;
		mask_back_group <= '0;
		load_const_model();

		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		monitor_on <= 1'b1;

		fill_all();
		repeat (4) next_cycle();
		for (int round = 0; round < ROUNDS; round++) begin
			n = 4 + int'(rand_word() % 8);
			repeat (n) random_write_cycle();
			repeat (4) next_cycle();
			n = 1 + int'(rand_word() % 12);
			repeat (n) issue_random_op();
			// VGPRs are read late in the pipe, so writes wait until the burst clears them
			repeat (4) next_cycle();
		end
		drain_results();

		$display("Errors: %0d value, %0d timing, %0d drain timeouts",
			value_errors, timing_errors, drain_timeouts);
		if (value_errors == 0 && timing_errors == 0 && drain_timeouts == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- files.f
+incdir+source
source/shader_pkg.sv
source/shader_regfile.sv
source/shader_const_rom.sv
source/shader_group_table.sv
source/shader_operand_ctrl.sv
source/shader_operand_mux.sv
source/shader_regs_top.sv
testbench/shader_regs_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the operand fetch testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module shader_regs_tb \
	--Mdir "$BUILD_DIR" \
	-f files.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/Vshader_regs_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	echo "Simulation reported failures, see $LOG"
	exit 1
fi

exit 0
